// File: sudoku_geom_pkg.sv
`default_nettype none

package sudoku_geom_pkg;

    localparam int GRID_DIM  = 9;
    localparam int BOX_DIM   = 3;
    localparam int NUM_CELLS = GRID_DIM * GRID_DIM;

    // 0 is an empty cell
    typedef logic [3:0]                   digit_t;
    typedef logic [6:0]                   cell_idx_t;
    // bit d-1 set means digit d still fits
    typedef logic [GRID_DIM-1:0]          digit_mask_t;
    typedef digit_t [NUM_CELLS-1:0]       grid_t;

    function automatic cell_idx_t row_base_of(input cell_idx_t idx);
        return cell_idx_t'((idx / GRID_DIM) * GRID_DIM);
    endfunction

    function automatic cell_idx_t col_of(input cell_idx_t idx);
        return cell_idx_t'(idx % GRID_DIM);
    endfunction

    function automatic cell_idx_t box_base_of(input cell_idx_t idx);
        cell_idx_t row;
        cell_idx_t col;
        row = cell_idx_t'(idx / GRID_DIM);
        col = col_of(idx);
        return cell_idx_t'((row / BOX_DIM) * BOX_DIM * GRID_DIM + (col / BOX_DIM) * BOX_DIM);
    endfunction

    // one-hot of a placed digit, nothing for an empty cell
    function automatic digit_mask_t digit_bit(input digit_t d);
        if (d >= 4'd1 && d <= 4'd9) begin
            return digit_mask_t'(1) << (d - 4'd1);
        end
        return '0;
    endfunction

    // digits missing from the row, column and box of idx
    function automatic digit_mask_t candidate_mask_of(input grid_t grid, input cell_idx_t idx);
        digit_mask_t mask;
        cell_idx_t   rb;
        cell_idx_t   cb;
        cell_idx_t   bb;
        mask = '1;
        rb   = row_base_of(idx);
        cb   = col_of(idx);
        bb   = box_base_of(idx);
        for (int k = 0; k < GRID_DIM; k++) begin
            mask &= ~digit_bit(grid[rb + k]);
            mask &= ~digit_bit(grid[cb + k * GRID_DIM]);
            mask &= ~digit_bit(grid[bb + (k / BOX_DIM) * GRID_DIM + k % BOX_DIM]);
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: sudoku_solve_pkg.sv
`default_nettype none

package sudoku_solve_pkg;

    // cell under test this cycle
    typedef struct packed {
        logic                       valid;
        sudoku_geom_pkg::cell_idx_t idx;
    } probe_t;

    // finder result
    typedef struct packed {
        logic                       found;
        sudoku_geom_pkg::digit_t    digit;
    } single_t;

    // registered grid write
    typedef struct packed {
        logic                       valid;
        sudoku_geom_pkg::cell_idx_t idx;
        sudoku_geom_pkg::digit_t    digit;
    } placement_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SWEEP,
        DRAIN,
        EMIT
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: sudoku_ctrl.sv
`default_nettype none

module sudoku_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  sudoku_geom_pkg::digit_t       in,
    input  sudoku_solve_pkg::placement_t  placement,
    input  logic                          sweep_progress,
    output sudoku_geom_pkg::grid_t        grid,
    output sudoku_solve_pkg::probe_t      probe,
    output logic                          sweep_clear,
    output logic                          out_valid,
    output sudoku_geom_pkg::digit_t       out
);
    import sudoku_geom_pkg::*;
    import sudoku_solve_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    // load position, sweep cursor and emit position share one counter
    cell_idx_t   cnt;
    cell_idx_t   cnt_nxt;
    logic        cnt_last;
    logic        grid_full;
    logic        go_emit;

    assign cnt_last = (cnt == cell_idx_t'(NUM_CELLS - 1));

    always_comb begin
        grid_full = 1'b1;
        for (int i = 0; i < NUM_CELLS; i++) begin
            if (grid[i] == '0) begin
                grid_full = 1'b0;
            end
        end
    end

    // stop when solved or when a whole sweep placed nothing
    assign go_emit = grid_full || !sweep_progress;

    // ==================================================================
    // state machine
    // ==================================================================
    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        case (state)
            IDLE: begin
                if (in_valid) begin
                    state_nxt = LOAD;
                    cnt_nxt   = cell_idx_t'(1);
                end
            end
            LOAD: begin
                if (in_valid) begin
                    state_nxt = cnt_last ? SWEEP : LOAD;
                    cnt_nxt   = cnt_last ? '0 : cnt + 7'd1;
                end
            end
            SWEEP: begin
                state_nxt = cnt_last ? DRAIN : SWEEP;
                cnt_nxt   = cnt_last ? '0 : cnt + 7'd1;
            end
            DRAIN: begin
                state_nxt = go_emit ? EMIT : SWEEP;
                cnt_nxt   = '0;
            end
            EMIT: begin
                state_nxt = cnt_last ? IDLE : EMIT;
                cnt_nxt   = cnt_last ? '0 : cnt + 7'd1;
            end
            default: begin
                state_nxt = IDLE;
                cnt_nxt   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    // ==================================================================
    // grid storage
    // ==================================================================
    always_ff @(posedge clk) begin
        if (state == EMIT && cnt_last) begin
            grid <= '0;
        end else if (in_valid && (state == IDLE || state == LOAD)) begin
            grid[cnt] <= in;
        end else if (placement.valid) begin
            grid[placement.idx] <= placement.digit;
        end
    end

    // only empty cells are worth probing
    assign probe.valid = (state == SWEEP) && (grid[cnt] == '0);
    assign probe.idx   = cnt;

    // idle clears leftover progress from the previous puzzle
    assign sweep_clear = (state == IDLE) || (state == DRAIN && !go_emit);

    // ==================================================================
    // result stream
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= (state == EMIT);
            out       <= (state == EMIT) ? grid[cnt] : '0;
        end
    end

endmodule

`default_nettype wire

// File: naked_single.sv
`default_nettype none

module naked_single (
    input  sudoku_geom_pkg::grid_t     grid,
    input  sudoku_geom_pkg::cell_idx_t idx,
    output sudoku_solve_pkg::single_t  result
);
    import sudoku_geom_pkg::*;

    digit_mask_t cand;
    logic        one_left;
    digit_t      digit;

    assign cand = candidate_mask_of(grid, idx);

    // exactly one bit set
    assign one_left = (cand != '0) && ((cand & (cand - 1'b1)) == '0);

    always_comb begin
        digit = '0;
        for (int d = 0; d < GRID_DIM; d++) begin
            if (cand[d]) begin
                digit = digit_t'(d + 1);
            end
        end
    end

    assign result.found = one_left;
    assign result.digit = one_left ? digit : '0;

endmodule

`default_nettype wire

// File: hidden_box_single.sv
`default_nettype none

module hidden_box_single (
    input  sudoku_geom_pkg::grid_t     grid,
    input  sudoku_geom_pkg::cell_idx_t idx,
    output sudoku_solve_pkg::single_t  result
);
    import sudoku_geom_pkg::*;

    digit_mask_t own;
    digit_mask_t others;
    digit_mask_t only_here;
    cell_idx_t   base;

    assign own  = candidate_mask_of(grid, idx);
    assign base = box_base_of(idx);

    // digits that some other empty cell of the box could still take
    always_comb begin
        cell_idx_t peer;
        others = '0;
        for (int k = 0; k < GRID_DIM; k++) begin
            peer = base + cell_idx_t'((k / BOX_DIM) * GRID_DIM + k % BOX_DIM);
            if (peer != idx && grid[peer] == '0) begin
                others |= candidate_mask_of(grid, peer);
            end
        end
    end

    assign only_here = own & ~others;

    // lowest qualifying digit wins
    always_comb begin
        result = '0;
        for (int d = GRID_DIM - 1; d >= 0; d--) begin
            if (only_here[d]) begin
                result.found = 1'b1;
                result.digit = digit_t'(d + 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: placement_arbiter.sv
`default_nettype none

module placement_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  sudoku_solve_pkg::probe_t      probe,
    input  sudoku_solve_pkg::single_t     naked,
    input  sudoku_solve_pkg::single_t     hidden,
    input  logic                          sweep_clear,
    output sudoku_solve_pkg::placement_t  placement,
    output logic                          sweep_progress
);
    import sudoku_solve_pkg::*;

    placement_t choice;

    // naked single first, hidden box single as fallback
    always_comb begin
        choice.valid = probe.valid && (naked.found || hidden.found);
        choice.idx   = probe.idx;
        choice.digit = naked.found ? naked.digit : hidden.digit;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            placement <= '0;
        end else begin
            placement <= choice;
        end
    end

    // did this sweep place anything
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_progress <= 1'b0;
        end else if (sweep_clear) begin
            sweep_progress <= 1'b0;
        end else if (choice.valid) begin
            sweep_progress <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: sudoku_top.sv
`default_nettype none

module sudoku_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  sudoku_geom_pkg::digit_t in,
    output logic                    out_valid,
    output sudoku_geom_pkg::digit_t out
);
    import sudoku_geom_pkg::*;
    import sudoku_solve_pkg::*;

    grid_t      grid;
    probe_t     probe;
    single_t    naked_result;
    single_t    hidden_result;
    placement_t placement;
    logic       sweep_clear;
    logic       sweep_progress;

    sudoku_ctrl sudoku_ctrl_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in             (in),
        .placement      (placement),
        .sweep_progress (sweep_progress),
        .grid           (grid),
        .probe          (probe),
        .sweep_clear    (sweep_clear),
        .out_valid      (out_valid),
        .out            (out)
    );

    naked_single naked_single_inst (
        .grid   (grid),
        .idx    (probe.idx),
        .result (naked_result)
    );

    hidden_box_single hidden_box_single_inst (
        .grid   (grid),
        .idx    (probe.idx),
        .result (hidden_result)
    );

    placement_arbiter placement_arbiter_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .probe          (probe),
        .naked          (naked_result),
        .hidden         (hidden_result),
        .sweep_clear    (sweep_clear),
        .placement      (placement),
        .sweep_progress (sweep_progress)
    );

endmodule

`default_nettype wire

// File: tb_sudoku_model.svh
`ifndef TB_SUDOKU_MODEL_SVH
`define TB_SUDOKU_MODEL_SVH

// ======================================================================
// puzzle generator
// ======================================================================
task automatic make_solution();
    int perm [10];
    int j;
    int tmp;
    int a;
    int b;
    for (int d = 1; d <= 9; d++) begin
        perm[d] = d;
    end
    // random relabel of the digits
    for (int d = 9; d > 1; d--) begin
        j = $urandom_range(d, 1);
        tmp = perm[d];
        perm[d] = perm[j];
        perm[j] = tmp;
    end
    for (int r = 0; r < 9; r++) begin
        for (int c = 0; c < 9; c++) begin
            solution[r * 9 + c] = perm[((r * 3 + r / 3 + c) % 9) + 1];
        end
    end
    // one row swap per band, one column swap per stack
    for (int band = 0; band < 3; band++) begin
        a = band * 3 + $urandom_range(2, 0);
        b = band * 3 + $urandom_range(2, 0);
        for (int k = 0; k < 9; k++) begin
            tmp = solution[a * 9 + k];
            solution[a * 9 + k] = solution[b * 9 + k];
            solution[b * 9 + k] = tmp;
        end
        a = band * 3 + $urandom_range(2, 0);
        b = band * 3 + $urandom_range(2, 0);
        for (int k = 0; k < 9; k++) begin
            tmp = solution[k * 9 + a];
            solution[k * 9 + a] = solution[k * 9 + b];
            solution[k * 9 + b] = tmp;
        end
    end
endtask

task automatic blank_cells(input int count);
    int idx;
    int left;
    for (int i = 0; i < CELLS; i++) begin
        puzzle[i] = solution[i];
    end
    left = count;
    while (left > 0) begin
        idx = $urandom_range(CELLS - 1, 0);
        if (puzzle[idx] != 0) begin
            puzzle[idx] = 0;
            left--;
        end
    end
endtask

// ======================================================================
// reference deduction on work[]
// ======================================================================
// bit d set when digit d still fits the cell
function automatic int free_mask(input int idx);
    int r;
    int c;
    int br;
    int bc;
    int used;
    r = idx / 9;
    c = idx % 9;
    br = r - r % 3;
    bc = c - c % 3;
    used = 0;
    for (int k = 0; k < 9; k++) begin
        used |= 1 << work[r * 9 + k];
        used |= 1 << work[k * 9 + c];
        used |= 1 << work[(br + k / 3) * 9 + bc + k % 3];
    end
    return ~used & 32'h3fe;
endfunction

function automatic int naked_digit(input int idx);
    int mask;
    mask = free_mask(idx);
    if ($countones(mask) == 1) begin
        return $clog2(mask);
    end
    return 0;
endfunction

function automatic int hidden_digit(input int idx);
    int br;
    int bc;
    int peer;
    int others;
    int own;
    br = (idx / 9) - (idx / 9) % 3;
    bc = (idx % 9) - (idx % 9) % 3;
    others = 0;
    for (int k = 0; k < 9; k++) begin
        peer = (br + k / 3) * 9 + bc + k % 3;
        if (peer != idx && work[peer] == 0) begin
            others |= free_mask(peer);
        end
    end
    own = free_mask(idx) & ~others;
    for (int d = 1; d <= 9; d++) begin
        if (own[d]) begin
            return d;
        end
    end
    return 0;
endfunction

// apply both rules until neither fires anywhere
task automatic solve_model();
    bit changed;
    int d;
    for (int i = 0; i < CELLS; i++) begin
        work[i] = puzzle[i];
    end
    changed = 1'b1;
    while (changed) begin
        changed = 1'b0;
        for (int i = 0; i < CELLS; i++) begin
            if (work[i] == 0) begin
                d = naked_digit(i);
                if (d == 0) begin
                    d = hidden_digit(i);
                end
                if (d != 0) begin
                    work[i] = d;
                    changed = 1'b1;
                end
            end
        end
    end
endtask

function automatic bit model_solved();
    for (int i = 0; i < CELLS; i++) begin
        if (work[i] != solution[i]) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

`endif

// File: tb_sudoku.sv
`default_nettype none

module tb_sudoku;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED         = 28878;
    localparam int CELLS        = 81;
    localparam int NUM_PUZZLES  = 12;
    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CYCLES = 20;
    // load, emit and up to 40 sweeps of 82 cycles per puzzle
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + QUIET_CYCLES
                                  + NUM_PUZZLES * (81 + 81 + 40 * 82);

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic [3:0] in_digit;
    logic       out_valid;
    logic [3:0] out_digit;

    int solution [CELLS];
    int puzzle [CELLS];
    int work [CELLS];
    int got [CELLS];
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    `include "tb_sudoku_model.svh"

    sudoku_top sudoku_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in        (in_digit),
        .out_valid (out_valid),
        .out       (out_digit)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the result stream never finished", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic send_puzzle();
        for (int i = 0; i < CELLS; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_digit <= 4'(puzzle[i]);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_digit <= '0;
    endtask

    // collect one result stream and measure its length
    task automatic receive_grid(input string name);
        int run;
        run = 0;
        @(negedge clk);
        while (!out_valid) begin
            @(negedge clk);
        end
        while (out_valid) begin
            if (run < CELLS) begin
                got[run] = int'(out_digit);
            end
            run++;
            @(negedge clk);
        end
        check_value({name, " out_valid run"}, CELLS, run);
    endtask

    task automatic run_puzzle(input string name, input int blanks, input bit need_full);
        int tries;
        make_solution();
        blank_cells(blanks);
        solve_model();
        tries = 0;
        // light puzzles must be fully solvable by the two rules
        while (need_full && !model_solved() && tries < 50) begin
            blank_cells(blanks);
            solve_model();
            tries++;
        end
        if (need_full && !model_solved()) begin
            errors++;
            $display("%s: could not build a puzzle that the rules solve fully", name);
        end
        send_puzzle();
        receive_grid(name);
        for (int i = 0; i < CELLS; i++) begin
            check_value($sformatf("%s cell %0d", name, i),
                        need_full ? solution[i] : work[i], got[i]);
            if (puzzle[i] != 0) begin
                check_value($sformatf("%s given %0d", name, i), puzzle[i], got[i]);
            end
        end
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial begin
        void'($urandom(SEED));
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        in_digit <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // nothing comes out before a puzzle goes in
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("idle out_valid", 0, int'(out_valid));
            check_value("idle out", 0, int'(out_digit));
        end

        run_puzzle("light", $urandom_range(15, 5), 1'b1);
        run_puzzle("heavy", $urandom_range(55, 40), 1'b0);
        for (int n = 0; n < NUM_PUZZLES - 2; n++) begin
            run_puzzle($sformatf("random%0d", n), $urandom_range(55, 5), 1'b0);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sudoku_top.f
+incdir+.
sudoku_geom_pkg.sv
sudoku_solve_pkg.sv
sudoku_ctrl.sv
naked_single.sv
hidden_box_single.sv
placement_arbiter.sv
sudoku_top.sv
tb_sudoku.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sudoku_top.f --top-module tb_sudoku -o sim_sudoku

output=$(./obj_dir/sim_sudoku)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
